// ==== wordGamePkg.sv ====
package wordGamePkg;

    // word geometry and game limits
    localparam int WORD_LEN     = 5;
    localparam int MAX_MISTAKES = 6;

    // one character code
    typedef logic [7:0] letter_t;

    // position within the word, 0 to WORD_LEN-1
    typedef logic [2:0] letterIdx_t;

    // bit i set once position i has been guessed
    typedef logic [WORD_LEN-1:0] foundMask_t;

    // hit or mistake counter
    typedef logic [2:0] count_t;

    // last scanned position
    localparam letterIdx_t LAST_IDX = letterIdx_t'(WORD_LEN - 1);

    // mistake count that turns the next miss into a loss
    localparam count_t LAST_MISTAKE = count_t'(MAX_MISTAKES - 1);

    typedef enum logic [2:0] {
        SETUP      = 3'd0,
        WAIT_GUESS = 3'd1,
        SCAN       = 3'd2,
        JUDGE      = 3'd3,
        WON        = 3'd4,
        LOST       = 3'd5
    } gameState_t;

endpackage

// ==== secretWordReg.sv ====
`timescale 1ns/100ps

module secretWordReg (
    input  logic                 clk,
    input  logic                 nRst,
    input  wordGamePkg::letter_t letterIn,
    input  logic                 loadLetter,
    input  logic                 clearWord,
    input  logic                 wordLocked,
    input  wordGamePkg::letterIdx_t letterSel,
    output wordGamePkg::letter_t letterOut,
    output logic                 wordValid
);
    import wordGamePkg::*;

    // five stored letters, index 0 is the oldest load
    letter_t word [WORD_LEN];

    // number of letters loaded, saturates at WORD_LEN
    letterIdx_t loadCount;

    logic loadEn;
    logic clearEn;

    // host strobes only count while the game is idle
    assign loadEn  = loadLetter && !wordLocked;
    assign clearEn = clearWord && !wordLocked;

    always_ff @(posedge clk, negedge nRst) begin
        if (!nRst) begin
            loadCount <= '0;
        end else if (clearEn) begin
            loadCount <= '0;
        end else if (loadEn && (loadCount != letterIdx_t'(WORD_LEN))) begin
            loadCount <= loadCount + 1'b1;
        end
    end

    // newest letter enters at the top and older ones move down,
    // so after five loads the first one sits at position 0
    always_ff @(posedge clk) begin
        if (loadEn && !clearEn) begin
            for (int i = 0; i < WORD_LEN - 1; i++) begin
                word[i] <= word[i+1];
            end
            word[WORD_LEN-1] <= letterIn;
        end
    end

    assign wordValid = (loadCount == letterIdx_t'(WORD_LEN));

    // letter under scan, straight from the array
    always_comb begin
        letterOut = '0;
        for (int i = 0; i < WORD_LEN; i++) begin
            if (letterSel == letterIdx_t'(i)) begin
                letterOut = word[i];
            end
        end
    end

    // the scanner in gameLogic must never step past the last letter
    selInRange: assert property (
        @(posedge clk) disable iff (!nRst)
        letterSel < letterIdx_t'(WORD_LEN)
    );

endmodule

// ==== gameLogic.sv ====
`timescale 1ns/100ps

module gameLogic (
    input  logic                    clk,
    input  logic                    nRst,
    input  wordGamePkg::letter_t    guess,
    input  logic                    guessStrobe,
    input  logic                    startGame,
    input  logic                    wordValid,
    input  wordGamePkg::letter_t    letterOut,
    output wordGamePkg::letterIdx_t letterSel,
    output logic                    wordLocked,
    output logic                    ready,
    output logic                    busy,
    output logic                    hit,
    output logic                    mistake,
    output logic                    won,
    output logic                    lost,
    output wordGamePkg::foundMask_t foundMask,
    output wordGamePkg::count_t     hitCount,
    output wordGamePkg::count_t     mistakeCount
);
    import wordGamePkg::*;

    gameState_t state;
    gameState_t nextState;

    // guess under scan
    letter_t guessReg;

    // set when the current guess matched any position
    logic matched;

    logic maskFull;
    logic guessTaken;

    assign maskFull   = &foundMask;
    assign guessTaken = (state == WAIT_GUESS) && guessStrobe;

    // next state
    always_comb begin
        nextState = state;
        case (state)
            SETUP: begin
                if (startGame && wordValid) begin
                    nextState = WAIT_GUESS;
                end
            end
            WAIT_GUESS: begin
                if (guessStrobe) begin
                    nextState = SCAN;
                end
            end
            SCAN: begin
                if (letterSel == LAST_IDX) begin
                    nextState = JUDGE;
                end
            end
            JUDGE: begin
                if (matched && maskFull) begin
                    nextState = WON;
                end else if (!matched && (mistakeCount == LAST_MISTAKE)) begin
                    // this miss is the sixth
                    nextState = LOST;
                end else begin
                    nextState = WAIT_GUESS;
                end
            end
            WON, LOST: begin
                if (startGame) begin
                    nextState = SETUP;
                end
            end
            default: begin
                nextState = SETUP;
            end
        endcase
    end

    always_ff @(posedge clk, negedge nRst) begin
        if (!nRst) begin
            state        <= SETUP;
            letterSel    <= '0;
            matched      <= 1'b0;
            foundMask    <= '0;
            hitCount     <= '0;
            mistakeCount <= '0;
            hit          <= 1'b0;
            mistake      <= 1'b0;
        end else begin
            state   <= nextState;
            // pulses last a single cycle
            hit     <= 1'b0;
            mistake <= 1'b0;

            case (state)
                SETUP: begin
                    // fresh round
                    if (nextState == WAIT_GUESS) begin
                        foundMask    <= '0;
                        hitCount     <= '0;
                        mistakeCount <= '0;
                    end
                end
                WAIT_GUESS: begin
                    if (guessStrobe) begin
                        letterSel <= '0;
                        matched   <= 1'b0;
                    end
                end
                SCAN: begin
                    // mask accumulates over the whole round
                    if (letterOut == guessReg) begin
                        foundMask[letterSel] <= 1'b1;
                        matched              <= 1'b1;
                    end
                    if (letterSel != LAST_IDX) begin
                        letterSel <= letterSel + 1'b1;
                    end
                end
                JUDGE: begin
                    if (matched) begin
                        hitCount <= hitCount + 1'b1;
                        hit      <= 1'b1;
                    end else begin
                        mistakeCount <= mistakeCount + 1'b1;
                        mistake      <= 1'b1;
                    end
                end
                default: begin
                end
            endcase
        end
    end

    // latched at the accepting edge and held through the scan
    always_ff @(posedge clk) begin
        if (guessTaken) begin
            guessReg <= guess;
        end
    end

    // status decoded from the state
    assign ready      = (state == SETUP) || (state == WAIT_GUESS);
    assign busy       = (state == SCAN) || (state == JUDGE);
    assign won        = (state == WON);
    assign lost       = (state == LOST);
    assign wordLocked = !((state == SETUP) || (state == WON) || (state == LOST));

    wonLostExclusive: assert property (
        @(posedge clk) disable iff (!nRst)
        !(won && lost)
    );

    busyReadyExclusive: assert property (
        @(posedge clk) disable iff (!nRst)
        !(busy && ready)
    );

endmodule

// ==== wordGameTop.sv ====
`timescale 1ns/100ps

module wordGameTop (
    input  logic                    clk,
    input  logic                    nRst,
    input  wordGamePkg::letter_t    letterIn,
    input  logic                    loadLetter,
    input  logic                    clearWord,
    input  logic                    startGame,
    input  wordGamePkg::letter_t    guess,
    input  logic                    guessStrobe,
    output logic                    ready,
    output logic                    busy,
    output logic                    hit,
    output logic                    mistake,
    output logic                    won,
    output logic                    lost,
    output wordGamePkg::foundMask_t foundMask,
    output wordGamePkg::count_t     hitCount,
    output wordGamePkg::count_t     mistakeCount
);
    import wordGamePkg::*;

    // scan path between the game logic and the word
    letterIdx_t letterSel;
    letter_t    letterOut;
    logic       wordValid;
    logic       wordLocked;

    secretWordReg u_secretWordReg (
        .clk        (clk),
        .nRst       (nRst),
        .letterIn   (letterIn),
        .loadLetter (loadLetter),
        .clearWord  (clearWord),
        .wordLocked (wordLocked),
        .letterSel  (letterSel),
        .letterOut  (letterOut),
        .wordValid  (wordValid)
    );

    gameLogic u_gameLogic (
        .clk          (clk),
        .nRst         (nRst),
        .guess        (guess),
        .guessStrobe  (guessStrobe),
        .startGame    (startGame),
        .wordValid    (wordValid),
        .letterOut    (letterOut),
        .letterSel    (letterSel),
        .wordLocked   (wordLocked),
        .ready        (ready),
        .busy         (busy),
        .hit          (hit),
        .mistake      (mistake),
        .won          (won),
        .lost         (lost),
        .foundMask    (foundMask),
        .hitCount     (hitCount),
        .mistakeCount (mistakeCount)
    );

endmodule

// ==== wordGameChecker.sv ====
`timescale 1ns/100ps

module wordGameChecker (
    input  logic                    clk,
    input  logic                    nRst,
    input  wordGamePkg::letter_t    letterIn,
    input  logic                    loadLetter,
    input  logic                    clearWord,
    input  logic                    startGame,
    input  wordGamePkg::letter_t    guess,
    input  logic                    guessStrobe,
    input  logic                    ready,
    input  logic                    busy,
    input  logic                    hit,
    input  logic                    mistake,
    input  logic                    won,
    input  logic                    lost,
    input  wordGamePkg::foundMask_t foundMask,
    input  wordGamePkg::count_t     hitCount,
    input  wordGamePkg::count_t     mistakeCount,
    input  int                      testId,
    output int                      passCount,
    output int                      failCount,
    output int                      errCount
);
    import wordGamePkg::*;

    typedef enum logic [2:0] {PH_SETUP, PH_OPEN, PH_BUSY, PH_WON, PH_LOST} phase_t;

    // model of the game as the DUT should see it before each edge
    phase_t     phase;
    letter_t    word [WORD_LEN];
    int         loaded;
    foundMask_t mask;
    foundMask_t pendMask;
    count_t     hits;
    count_t     misses;
    logic       pendHit;
    logic       judged;
    int         cyc;
    int         lastId;
    int         errAtStart;

    function automatic string testName(input int id);
        case (id)
            0: return "reset";
            1: return "partial word";
            2: return "random round";
            3: return "win";
            4: return "loss";
            default: return "busy drops";
        endcase
    endfunction

    task automatic compare(input string what, input int expVal, input int actVal);
        if (expVal != actVal) begin
            errCount++;
            $display("[FAIL] %s %s: expected %0h, actual %0h",
                     testName(testId), what, expVal, actVal);
        end
    endtask

    always @(posedge clk) begin
        if (!nRst) begin
            phase      = PH_SETUP;
            loaded     = 0;
            mask       = '0;
            hits       = '0;
            misses     = '0;
            pendHit    = 1'b0;
            cyc        = 0;
            lastId     = testId;
            passCount  = 0;
            failCount  = 0;
            errCount   = 0;
            errAtStart = 0;
        end else begin
            // previous test is over once the test id moves on
            if (testId != lastId) begin
                if (errCount == errAtStart) begin
                    passCount++;
                    $display("test %s: passed", testName(lastId));
                end else begin
                    failCount++;
                    $display("test %s: %0d mismatches", testName(lastId), errCount - errAtStart);
                end
                errAtStart = errCount;
                lastId     = testId;
            end

            // verdict is visible seven edges after the accepting edge
            judged = 1'b0;
            if (phase == PH_BUSY) begin
                cyc++;
                if (cyc == 7) begin
                    judged = 1'b1;
                    mask   = pendMask;
                    if (pendHit) begin
                        hits++;
                    end else begin
                        misses++;
                    end
                    if (pendHit && (&mask)) begin
                        phase = PH_WON;
                    end else if (!pendHit && misses == count_t'(MAX_MISTAKES)) begin
                        phase = PH_LOST;
                    end else begin
                        phase = PH_OPEN;
                    end
                end
            end

            compare("ready", int'(phase == PH_SETUP || phase == PH_OPEN), int'(ready));
            compare("busy", int'(phase == PH_BUSY), int'(busy));
            compare("won", int'(phase == PH_WON), int'(won));
            compare("lost", int'(phase == PH_LOST), int'(lost));
            compare("hit", int'(judged && pendHit), int'(hit));
            compare("mistake", int'(judged && !pendHit), int'(mistake));
            // mask fills position by position during the scan
            if (phase != PH_BUSY) begin
                compare("foundMask", int'(mask), int'(foundMask));
            end
            compare("hitCount", int'(hits), int'(hitCount));
            compare("mistakeCount", int'(misses), int'(mistakeCount));

            // host side only while no round is running
            if (phase != PH_OPEN && phase != PH_BUSY) begin
                if (clearWord) begin
                    loaded = 0;
                end else if (loadLetter) begin
                    for (int i = 0; i < WORD_LEN - 1; i++) begin
                        word[i] = word[i+1];
                    end
                    word[WORD_LEN-1] = letterIn;
                    if (loaded < WORD_LEN) begin
                        loaded++;
                    end
                end
            end

            if (startGame && phase == PH_SETUP && loaded == WORD_LEN) begin
                phase  = PH_OPEN;
                mask   = '0;
                hits   = '0;
                misses = '0;
            end else if (startGame && (phase == PH_WON || phase == PH_LOST)) begin
                phase = PH_SETUP;
            end else if (guessStrobe && phase == PH_OPEN) begin
                pendMask = mask;
                pendHit  = 1'b0;
                for (int i = 0; i < WORD_LEN; i++) begin
                    if (word[i] == guess) begin
                        pendMask[i] = 1'b1;
                        pendHit     = 1'b1;
                    end
                end
                phase = PH_BUSY;
                cyc   = 0;
            end
        end
    end

endmodule

// ==== wordGameTb.sv ====
`timescale 1ns/100ps

module wordGameTb;
    import wordGamePkg::*;

    localparam int WAIT_LIMIT = 40;

    logic        clk;
    logic        nRst;
    letter_t     letterIn;
    letter_t     guess;
    logic        loadLetter, clearWord, startGame, guessStrobe;
    logic        ready, busy, hit, mistake, won, lost;
    foundMask_t  foundMask;
    count_t      hitCount;
    count_t      mistakeCount;
    int          testId;
    int          passCount;
    int          failCount;
    int          errCount;
    logic        timedOut;
    logic [31:0] rngState;

    wordGameTop u_wordGameTop (.*);

    wordGameChecker u_wordGameChecker (.*);

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    function automatic logic [31:0] xorshift(input logic [31:0] s);
        logic [31:0] x;
        x = s ^ (s << 13);
        x = x ^ (x >> 17);
        return x ^ (x << 5);
    endfunction

    task automatic loadByte(input letter_t l);
        @(negedge clk);
        letterIn   = l;
        loadLetter = 1'b1;
        @(negedge clk);
        loadLetter = 1'b0;
    endtask

    // one-cycle strobe on clearWord and/or startGame
    task automatic pulseControl(input logic doClear, input logic doStart);
        @(negedge clk);
        clearWord = doClear;
        startGame = doStart;
        @(negedge clk);
        clearWord = 1'b0;
        startGame = 1'b0;
    endtask

    // strobe held for extra cycles past the first, then wait for hit or mistake
    task automatic play(input letter_t g, input int extra, input logic verdict);
        int n;
        @(negedge clk);
        guess       = g;
        guessStrobe = 1'b1;
        repeat (extra + 1) @(negedge clk);
        guessStrobe = 1'b0;
        n = 0;
        while (verdict && !timedOut && !(hit || mistake) && n < WAIT_LIMIT) begin
            @(negedge clk);
            n++;
        end
        if (verdict && n == WAIT_LIMIT) begin
            timedOut = 1'b1;
            $display("timeout: no hit or mistake pulse after guess %c", g);
        end
        @(negedge clk);
    endtask

    initial begin
        string secret;
        string alphabet;
        secret      = "APPLE";
        // word letters first, absent letters after
        alphabet    = "APLEXZQK";
        rngState    = 32'd37;
        timedOut    = 1'b0;
        testId      = 0;
        nRst        = 1'b0;
        letterIn    = '0;
        guess       = '0;
        loadLetter  = 1'b0;
        clearWord   = 1'b0;
        startGame   = 1'b0;
        guessStrobe = 1'b0;
        repeat (16) @(posedge clk);
        @(negedge clk);
        nRst = 1'b1;
        repeat (3) @(negedge clk);

        // start refused with only three letters loaded
        testId = 1;
        for (int i = 0; i < 3; i++) begin
            loadByte(secret[i]);
        end
        pulseControl(1'b0, 1'b1);
        play("A", 0, 1'b0);
        pulseControl(1'b1, 1'b0);

        testId = 2;
        for (int i = 0; i < WORD_LEN; i++) begin
            loadByte(secret[i]);
        end
        pulseControl(1'b0, 1'b1);
        for (int i = 0; i < 40 && !won && !lost; i++) begin
            rngState = xorshift(rngState);
            play(alphabet[int'(rngState[2:0])], 0, 1'b1);
        end
        pulseControl(1'b0, 1'b1);

        // every distinct letter once, then a guess after the win
        testId = 3;
        pulseControl(1'b0, 1'b1);
        for (int i = 0; i < 4; i++) begin
            play(alphabet[i], 0, 1'b1);
        end
        play("X", 0, 1'b0);
        pulseControl(1'b0, 1'b1);

        // host traffic during the round must not reach the word
        testId = 4;
        pulseControl(1'b0, 1'b1);
        loadByte("Q");
        pulseControl(1'b1, 1'b0);
        for (int i = 0; i < 6; i++) begin
            play(alphabet[4 + i % 4], 0, 1'b1);
        end
        pulseControl(1'b0, 1'b1);

        testId = 5;
        pulseControl(1'b0, 1'b1);
        play("P", 4, 1'b1);
        play("K", 3, 1'b1);
        play("L", 2, 1'b1);
        testId = 6;
        repeat (3) @(negedge clk);

        $display("tests passed %0d, tests failed %0d, mismatches %0d",
                 passCount, failCount, errCount);
        if (failCount == 0 && errCount == 0 && !timedOut) begin
            $display("All checks passed");
        end else begin
            $display("Checks failed");
        end
        $finish;
    end

endmodule

// ==== filelist.f ====
wordGamePkg.sv
secretWordReg.sv
gameLogic.sv
wordGameTop.sv
wordGameChecker.sv
wordGameTb.sv

// ==== run.sh ====
#!/bin/sh
# build the testbench with Verilator, run it, then scan the log
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -f filelist.f --top-module wordGameTb -o simWordGame

./obj_dir/simWordGame > sim.log 2>&1
cat sim.log

if grep -q "Checks failed" sim.log; then
    exit 1
fi
echo "simulation run clean"
